//--- sources.f
+incdir+rtl
rtl/pic_pkg.sv
rtl/pic_command_decoder.sv
rtl/pic_interrupt_core.sv
rtl/pic_acknowledge_sequencer.sv
rtl/pic_top.sv
tb/pic_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the PIC testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sources.f --top-module pic_tb -o pic_sim

output=$(./obj_dir/pic_sim)
echo "$output"

# Exit status is that of the search for the pass message.
echo "$output" | grep -qx "No errors"

//--- tb/pic_tb.sv
`include "pic_params.svh"
`default_nettype none

module pic_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import pic_pkg::*;

	localparam int CYCLE_LIMIT = 5000; // tests need about 1500 cycles.

	logic clock;
	logic reset;
	logic inta_n;
	bus_write_t bus;
	logic [`PIC_LEVELS-1:0] requests;
	logic interrupt_to_cpu;
	logic data_out_valid;
	logic [`PIC_BUS_WIDTH-1:0] data_out;

	// testbench model of the controller state.
	logic [`PIC_LEVELS-1:0] model_irr;
	logic [`PIC_LEVELS-1:0] model_isr;
	logic [`PIC_LEVELS-1:0] model_mask;
	logic [4:0] model_base;
	logic model_auto_eoi;
	logic model_level_mode;

	logic [31:0] lfsr_state;
	int cycle_count = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	logic compare_request = 1'b0;
	logic check_vector;
	logic expected_irq;
	logic [`PIC_BUS_WIDTH-1:0] expected_vector;
	string check_label;

	pic_top DUT (
		.clock(clock),
		.reset(reset),
		.inta_n(inta_n),
		.bus(bus),
		.interrupt_request(requests),
		.interrupt_to_cpu(interrupt_to_cpu),
		.data_out_valid(data_out_valid),
		.data_out(data_out)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: tests did not finish");
			$display("Errors found");
			$finish;
		end
	end

	// expected {flag, vector} with the spurious level when nothing is eligible.
	function automatic logic [8:0] expected_response(input logic [4:0] base,
		input logic [7:0] irr, input logic [7:0] mask, input logic [7:0] isr);
		logic found;
		logic blocked;
		logic [2:0] level;
		found = 1'b0;
		blocked = 1'b0;
		level = 3'(`PIC_SPURIOUS_LEVEL);
		for (int i = 0; i < `PIC_LEVELS; i++) begin
			if (isr[i])
				blocked = 1'b1; // same level blocks too.
			if (!found && !blocked && irr[i] && !mask[i]) begin
				found = 1'b1;
				level = 3'(i);
			end
		end
		return {found, base, level};
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	always begin
		wait (compare_request);
		if (check_vector) begin
			assert (data_out_valid && data_out == expected_vector) else begin
				$display("CHECK FAILED at %0t: %s vector %02h valid %b, expected %02h",
					$time, check_label, data_out, data_out_valid, expected_vector);
				test_errors++;
			end
		end else begin
			assert (interrupt_to_cpu == expected_irq) else begin
				$display("CHECK FAILED at %0t: %s interrupt %b, expected %b",
					$time, check_label, interrupt_to_cpu, expected_irq);
				test_errors++;
			end
			assert (!data_out_valid && data_out == 8'h00) else begin
				$display("CHECK FAILED at %0t: %s data_out %02h valid %b while idle",
					$time, check_label, data_out, data_out_valid);
				test_errors++;
			end
		end
		compare_request = 1'b0;
	end

	task automatic random_byte(output logic [7:0] value);
		value = 8'h00;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value[i] = lfsr_state[0];
		end
	endtask

	task automatic write_bus(input logic a0, input logic [7:0] data);
		bus = '{write: 1'b1, a0: a0, data: data};
		@(negedge clock);
		bus = '{write: 1'b0, a0: 1'b0, data: 8'h00};
	endtask

	task automatic initialize(input logic level_mode, input logic with_icw4,
		input logic auto_eoi, input logic [7:0] icw2);
		write_bus(1'b0, {3'b000, 1'b1, level_mode, 2'b00, with_icw4});
		write_bus(1'b1, icw2);
		if (with_icw4)
			write_bus(1'b1, {6'b000000, auto_eoi, 1'b1});
		model_irr = level_mode ? requests : 8'h00;
		model_isr = 8'h00;
		model_mask = 8'h00;
		model_base = icw2[7:3];
		model_auto_eoi = with_icw4 & auto_eoi;
		model_level_mode = level_mode;
	endtask

	task automatic write_mask(input logic [7:0] value);
		write_bus(1'b1, value);
		model_mask = value;
	endtask

	task automatic end_of_interrupt(input logic specific, input logic [2:0] level);
		logic found;
		found = 1'b0;
		write_bus(1'b0, specific ? {3'b011, 2'b00, level} : 8'h20);
		if (specific) begin
			model_isr[level] = 1'b0;
		end else begin
			for (int i = 0; i < `PIC_LEVELS; i++) begin
				if (!found && model_isr[i]) begin
					model_isr[i] = 1'b0;
					found = 1'b1;
				end
			end
		end
	endtask

	task automatic set_requests(input logic [7:0] value);
		logic [7:0] rising;
		rising = value & ~requests;
		requests = value;
		if (model_level_mode)
			model_irr = value;
		else
			model_irr = model_irr | rising;
	endtask

	task automatic check_interrupt_line(input string label);
		logic [8:0] response;
		repeat (4) @(negedge clock);
		response = expected_response(model_base, model_irr, model_mask, model_isr);
		expected_irq = response[8];
		check_vector = 1'b0;
		check_label = label;
		compare_request = 1'b1;
		wait (!compare_request);
	endtask

	// two inta_n pulses of 3 cycles low with 3 cycles high between.
	task automatic acknowledge(input string label);
		logic [8:0] response;
		response = expected_response(model_base, model_irr, model_mask, model_isr);
		inta_n = 1'b0;
		repeat (3) @(negedge clock);
		inta_n = 1'b1;
		repeat (3) @(negedge clock);
		inta_n = 1'b0;
		repeat (2) @(negedge clock);
		expected_vector = response[7:0];
		check_vector = 1'b1;
		check_label = label;
		compare_request = 1'b1;
		wait (!compare_request);
		@(negedge clock);
		inta_n = 1'b1;
		if (response[8]) begin
			model_isr[response[2:0]] = !model_auto_eoi;
			if (!model_level_mode)
				model_irr[response[2:0]] = 1'b0;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	initial begin
		logic [7:0] pattern;
		logic [8:0] response;
		clock = 1'b0;
		reset = 1'b1;
		inta_n = 1'b1;
		bus = '{write: 1'b0, a0: 1'b0, data: 8'h00};
		requests = 8'h00;
		lfsr_state = 32'hc004_933b;
		model_level_mode = 1'b0;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		initialize(1'b0, 1'b0, 1'b0, 8'h20);
		set_requests(8'h10);
		check_interrupt_line("edge raise");
		acknowledge("edge vector");
		check_interrupt_line("edge after ack");
		end_of_interrupt(1'b0, 3'd0);
		set_requests(8'h00);
		check_interrupt_line("edge after eoi");
		finish_test("edge request");

		for (int n = 0; n < 20; n++) begin
			random_byte(pattern);
			set_requests(pattern);
			check_interrupt_line("priority raise");
			response = expected_response(model_base, model_irr, model_mask, model_isr);
			while (response[8]) begin
				acknowledge("priority vector");
				end_of_interrupt(1'b0, 3'd0);
				check_interrupt_line("priority after eoi");
				response = expected_response(model_base, model_irr, model_mask, model_isr);
			end
			set_requests(8'h00);
			repeat (4) @(negedge clock);
		end
		finish_test("priority");

		write_mask(8'h08);
		set_requests(8'h08);
		check_interrupt_line("masked level");
		write_mask(8'h00);
		check_interrupt_line("unmasked level");
		acknowledge("unmasked vector");
		end_of_interrupt(1'b0, 3'd0);
		set_requests(8'h00);
		check_interrupt_line("mask cleanup");
		finish_test("mask");

		set_requests(8'h08);
		check_interrupt_line("nest level 3");
		acknowledge("nest vector 3");
		check_interrupt_line("nest level 3 in service");
		set_requests(8'h28);
		check_interrupt_line("nest level 5 blocked");
		set_requests(8'h2a);
		check_interrupt_line("nest level 1 raised");
		acknowledge("nest vector 1");
		check_interrupt_line("nest levels 1 and 3 in service");
		end_of_interrupt(1'b0, 3'd0);
		check_interrupt_line("nest level 1 cleared");
		end_of_interrupt(1'b1, 3'd3);
		check_interrupt_line("nest level 5 through");
		acknowledge("nest vector 5");
		end_of_interrupt(1'b0, 3'd0);
		set_requests(8'h00);
		check_interrupt_line("nest cleanup");
		finish_test("nesting");

		initialize(1'b0, 1'b1, 1'b1, 8'h48);
		set_requests(8'h44);
		check_interrupt_line("auto eoi raise");
		acknowledge("auto eoi vector 2");
		check_interrupt_line("auto eoi level 6 next");
		acknowledge("auto eoi vector 6");
		check_interrupt_line("auto eoi idle");
		acknowledge("spurious vector");
		set_requests(8'h00);
		check_interrupt_line("auto eoi cleanup");
		finish_test("auto eoi");

		initialize(1'b1, 1'b0, 1'b0, 8'h80);
		set_requests(8'h01);
		check_interrupt_line("level raise");
		acknowledge("level vector");
		check_interrupt_line("level in service");
		end_of_interrupt(1'b0, 3'd0);
		check_interrupt_line("level raised again");
		acknowledge("level vector again");
		end_of_interrupt(1'b0, 3'd0);
		set_requests(8'h00);
		check_interrupt_line("level dropped");
		initialize(1'b0, 1'b0, 1'b0, 8'h80);
		set_requests(8'h01);
		check_interrupt_line("edge held raise");
		acknowledge("edge held vector");
		end_of_interrupt(1'b0, 3'd0);
		check_interrupt_line("edge held not again"); // no new edge while held.
		set_requests(8'h00);
		check_interrupt_line("edge held cleanup");
		finish_test("level mode");

		$display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/pic_top.sv
`include "pic_params.svh"
`default_nettype none

module pic_top (
	input logic clock,
	input logic reset,
	input logic inta_n,
	input pic_pkg::bus_write_t bus,
	input logic [`PIC_LEVELS-1:0] interrupt_request,
	output logic interrupt_to_cpu,
	output logic data_out_valid,
	output logic [`PIC_BUS_WIDTH-1:0] data_out
);
	import pic_pkg::*;

	pic_config_t cfg;
	logic [`PIC_LEVELS-1:0] mask;
	eoi_cmd_t eoi;
	logic init_pulse;
	pending_t pending;
	logic take;
	logic done;
	logic [`PIC_LEVEL_BITS-1:0] done_level;

	pic_command_decoder u_decoder (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.cfg(cfg),
		.mask(mask),
		.eoi(eoi),
		.init_pulse(init_pulse)
	);

	pic_interrupt_core u_core (
		.clock(clock),
		.reset(reset),
		.init_pulse(init_pulse),
		.take(take),
		.done(done),
		.cfg(cfg),
		.mask(mask),
		.eoi(eoi),
		.interrupt_request(interrupt_request),
		.done_level(done_level),
		.pending(pending),
		.interrupt_to_cpu(interrupt_to_cpu)
	);

	pic_acknowledge_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.inta_n(inta_n),
		.cfg(cfg),
		.pending(pending),
		.take(take),
		.done(done),
		.done_level(done_level),
		.data_out(data_out),
		.data_out_valid(data_out_valid)
	);

endmodule

`default_nettype wire

//--- rtl/pic_acknowledge_sequencer.sv
`include "pic_params.svh"
`default_nettype none

module pic_acknowledge_sequencer (
	input logic clock,
	input logic reset,
	input logic inta_n,
	input pic_pkg::pic_config_t cfg,
	input pic_pkg::pending_t pending,
	output logic take,
	output logic done,
	output logic [`PIC_LEVEL_BITS-1:0] done_level,
	output logic [`PIC_BUS_WIDTH-1:0] data_out,
	output logic data_out_valid
);
	import pic_pkg::*;

	ack_state_e state;
	logic inta_sampled;
	logic inta_prev;
	logic inta_fall;
	logic inta_rise;
	logic [`PIC_LEVEL_BITS-1:0] ack_level;

	always_ff @(posedge clock) begin
		if (reset) begin
			inta_sampled <= 1'b1;
			inta_prev <= 1'b1;
		end else begin
			inta_sampled <= inta_n;
			inta_prev <= inta_sampled;
		end
	end

	assign inta_fall = inta_prev & ~inta_sampled;
	assign inta_rise = ~inta_prev & inta_sampled;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ACK_IDLE;
			take <= 1'b0;
			done <= 1'b0;
		end else begin
			take <= 1'b0;
			done <= 1'b0;
			case (state)
				ACK_IDLE: begin
					if (inta_fall) begin
						state <= ACK_FIRST;
						take <= 1'b1;
					end
				end
				ACK_FIRST: begin
					if (inta_fall)
						state <= ACK_SECOND;
				end
				ACK_SECOND: begin
					if (inta_rise) begin
						state <= ACK_IDLE;
						done <= 1'b1;
					end
				end
				default: state <= ACK_IDLE;
			endcase
		end
	end

	// same cycle the core moves pending.level into service.
	always_ff @(posedge clock) begin
		if (take)
			ack_level <= pending.valid ? pending.level
				: `PIC_LEVEL_BITS'(`PIC_SPURIOUS_LEVEL);
	end

	assign done_level = ack_level;
	assign data_out_valid = (state == ACK_SECOND);
	assign data_out = data_out_valid ? {cfg.vector_base, ack_level} : '0; // 8086 vector.

endmodule

`default_nettype wire

//--- rtl/pic_interrupt_core.sv
`include "pic_params.svh"
`default_nettype none

module pic_interrupt_core (
	input logic clock,
	input logic reset,
	input logic init_pulse,
	input logic take,
	input logic done,
	input pic_pkg::pic_config_t cfg,
	input logic [`PIC_LEVELS-1:0] mask,
	input pic_pkg::eoi_cmd_t eoi,
	input logic [`PIC_LEVELS-1:0] interrupt_request,
	input logic [`PIC_LEVEL_BITS-1:0] done_level,
	output pic_pkg::pending_t pending,
	output logic interrupt_to_cpu
);
	import pic_pkg::*;

	logic [`PIC_LEVELS-1:0] request_sampled;
	logic [`PIC_LEVELS-1:0] request_prev;
	logic [`PIC_LEVELS-1:0] request_edge;
	logic [`PIC_LEVELS-1:0] request_reg;
	logic [`PIC_LEVELS-1:0] in_service;
	logic [`PIC_LEVELS-1:0] eligible;
	logic [`PIC_LEVELS-1:0] take_bit;
	logic [`PIC_LEVELS-1:0] service_clear;
	logic blocked;

	// fixed priority, lowest index wins.
	function automatic logic [`PIC_LEVEL_BITS-1:0] lowest_set(input logic [`PIC_LEVELS-1:0] bits);
		logic [`PIC_LEVEL_BITS-1:0] index;
		index = '0;
		for (int i = `PIC_LEVELS - 1; i >= 0; i--) begin
			if (bits[i])
				index = `PIC_LEVEL_BITS'(i);
		end
		return index;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			request_sampled <= '0;
			request_prev <= '0;
		end else begin
			request_sampled <= interrupt_request;
			request_prev <= request_sampled;
		end
	end

	assign request_edge = request_sampled & ~request_prev;

	always_comb begin
		take_bit = '0;
		if (take && pending.valid)
			take_bit[pending.level] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset || init_pulse)
			request_reg <= '0;
		else if (cfg.level_triggered)
			request_reg <= request_sampled & ~take_bit;
		else
			request_reg <= (request_reg | request_edge) & ~take_bit; // held until taken.
	end

	always_comb begin
		service_clear = '0;
		case (eoi.op)
			EOI_NONSPECIFIC: begin
				if (|in_service)
					service_clear[lowest_set(in_service)] = 1'b1;
			end
			EOI_SPECIFIC: service_clear[eoi.level] = 1'b1;
			default: service_clear = '0;
		endcase
		if (done && cfg.auto_eoi)
			service_clear[done_level] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset || init_pulse)
			in_service <= '0;
		else
			in_service <= (in_service & ~service_clear) | take_bit;
	end

	// a level is blocked by any in-service bit at or above its priority.
	always_comb begin
		blocked = 1'b0;
		eligible = '0;
		for (int i = 0; i < `PIC_LEVELS; i++) begin
			blocked = blocked | in_service[i];
			eligible[i] = request_reg[i] & ~mask[i] & ~blocked;
		end
	end

	assign pending.valid = |eligible;
	assign pending.level = lowest_set(eligible);

	always_ff @(posedge clock) begin
		if (reset)
			interrupt_to_cpu <= 1'b0;
		else
			interrupt_to_cpu <= pending.valid & cfg.ready;
	end

endmodule

`default_nettype wire

//--- rtl/pic_command_decoder.sv
`include "pic_params.svh"
`default_nettype none

module pic_command_decoder (
	input logic clock,
	input logic reset,
	input pic_pkg::bus_write_t bus,
	output pic_pkg::pic_config_t cfg,
	output logic [`PIC_LEVELS-1:0] mask,
	output pic_pkg::eoi_cmd_t eoi,
	output logic init_pulse
);
	import pic_pkg::*;

	init_state_e state;
	logic icw4_needed;
	logic level_triggered;
	logic auto_eoi;
	logic [`PIC_BUS_WIDTH-`PIC_LEVEL_BITS-1:0] vector_base;
	logic write_icw1;
	logic write_init_word;
	logic write_ocw1;
	logic write_ocw2;

	assign write_icw1 = bus.write & ~bus.a0 & bus.data[4];
	assign write_init_word = bus.write & bus.a0 & (state != INIT_READY); // icw2 or icw4.
	assign write_ocw1 = bus.write & bus.a0 & (state == INIT_READY);
	assign write_ocw2 = bus.write & ~bus.a0 & ~bus.data[4] & ~bus.data[3]
		& (state == INIT_READY);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= INIT_WAIT_ICW2;
			icw4_needed <= 1'b0;
			level_triggered <= 1'b0;
			auto_eoi <= 1'b0;
			vector_base <= '0;
		end else if (write_icw1) begin
			state <= INIT_WAIT_ICW2;
			icw4_needed <= bus.data[0];
			level_triggered <= bus.data[3];
			auto_eoi <= 1'b0;
		end else if (write_init_word) begin
			case (state)
				INIT_WAIT_ICW2: begin
					vector_base <= bus.data[`PIC_BUS_WIDTH-1:`PIC_LEVEL_BITS];
					state <= icw4_needed ? INIT_WAIT_ICW4 : INIT_READY;
				end
				INIT_WAIT_ICW4: begin
					auto_eoi <= bus.data[1];
					state <= INIT_READY;
				end
				default: begin
					state <= INIT_READY;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset || write_icw1)
			mask <= '0;
		else if (write_ocw1)
			mask <= bus.data[`PIC_LEVELS-1:0];
	end

	always_ff @(posedge clock) begin
		if (reset)
			init_pulse <= 1'b0;
		else
			init_pulse <= write_icw1; // clears irr and isr in the core.
	end

	// ocw2 code in bits 7:5, other codes ignored.
	always_ff @(posedge clock) begin
		if (reset) begin
			eoi <= '{op: EOI_NONE, level: '0};
		end else begin
			eoi.op <= EOI_NONE;
			eoi.level <= bus.data[`PIC_LEVEL_BITS-1:0];
			if (write_ocw2) begin
				case (bus.data[7:5])
					3'b001: eoi.op <= EOI_NONSPECIFIC;
					3'b011: eoi.op <= EOI_SPECIFIC;
					default: eoi.op <= EOI_NONE;
				endcase
			end
		end
	end

	assign cfg = '{
		ready: (state == INIT_READY),
		level_triggered: level_triggered,
		auto_eoi: auto_eoi,
		vector_base: vector_base
	};

endmodule

`default_nettype wire

//--- rtl/pic_pkg.sv
`include "pic_params.svh"
`default_nettype none

package pic_pkg;

	typedef enum logic [1:0] {
		INIT_WAIT_ICW2,
		INIT_WAIT_ICW4,
		INIT_READY
	} init_state_e;

	typedef enum logic [1:0] {
		ACK_IDLE,
		ACK_FIRST,
		ACK_SECOND
	} ack_state_e;

	typedef enum logic [1:0] {
		EOI_NONE,
		EOI_NONSPECIFIC,
		EOI_SPECIFIC
	} eoi_op_e;

	typedef struct packed {
		logic write; // one-cycle strobe.
		logic a0;
		logic [`PIC_BUS_WIDTH-1:0] data;
	} bus_write_t;

	typedef struct packed {
		logic ready; // init complete.
		logic level_triggered;
		logic auto_eoi;
		logic [`PIC_BUS_WIDTH-`PIC_LEVEL_BITS-1:0] vector_base;
	} pic_config_t;

	typedef struct packed {
		eoi_op_e op;
		logic [`PIC_LEVEL_BITS-1:0] level; // specific eoi only.
	} eoi_cmd_t;

	typedef struct packed {
		logic valid;
		logic [`PIC_LEVEL_BITS-1:0] level;
	} pending_t;

endpackage

`default_nettype wire

//--- rtl/pic_params.svh
`ifndef PIC_PARAMS_SVH
`define PIC_PARAMS_SVH

`default_nettype none

// request levels, level 0 has the highest priority.
`define PIC_LEVELS 8

// width of a level index.
`define PIC_LEVEL_BITS 3

`define PIC_BUS_WIDTH 8 // data bus.

// reported on an acknowledge with nothing eligible.
`define PIC_SPURIOUS_LEVEL 7

`default_nettype wire

`endif
